//--- src/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // geometry
    localparam int NWAY = 2;
    localparam int NSET = 16;

    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;

    // byte address is split as {tag, index, offset}
    localparam int OFFSET_W = 4;
    localparam int INDEX_W  = $clog2(NSET);
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    // four words per line, word 0 at the lowest address
    typedef logic [(2 ** (OFFSET_W - 2)) - 1:0][WORD_W-1:0] line_t;

    typedef struct packed {
        logic             valid;
        logic             dirty;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    // stage-2 request together with what every way returned for its set
    typedef struct packed {
        logic                  valid;
        logic                  we;
        logic [ADDR_W-1:0]     addr;
        logic [WORD_W/8-1:0]   wstrb;
        logic [WORD_W-1:0]     wdata;
        tag_entry_t [NWAY-1:0] tags;
        line_t [NWAY-1:0]      lines;
    } lookup_t;

endpackage

`default_nettype wire

//--- src/bus_pkg.sv
`default_nettype none

package bus_pkg;

    // wishbone classic, 32-bit data and byte address
    localparam int WB_DW = 32;
    localparam int WB_AW = 32;

    localparam int WB_SW = WB_DW / 8;

    // one cache line moves as this many single-word cycles
    localparam int LINE_WORDS = 4;

endpackage

`default_nettype wire

//--- src/dcache_ifs.sv
`timescale 1ns/1ns
`default_nettype none

// one write port shared by the tag and line arrays of all ways
interface array_wr_if
    import cache_pkg::*;
();
    logic             we;
    // one-hot, more than one bit only while clearing the tags
    logic [NWAY-1:0]  way;
    logic [INDEX_W-1:0] index;
    tag_entry_t       tag;
    line_t            line;

    modport ctrl (output we, way, index, tag, line);
    modport arrays (input we, way, index, tag, line);
endinterface

// whole-line transfer between the controller and the bus master
interface mem_line_if
    import cache_pkg::*, bus_pkg::*;
();
    logic             start;
    logic             we;
    logic [WB_AW-1:0] addr;
    line_t            wline;
    line_t            rline;
    logic             done;

    modport ctrl (
        output start, we, addr, wline,
        input  rline, done
    );
    modport master (
        input  start, we, addr, wline,
        output rline, done
    );
endinterface

`default_nettype wire

//--- src/cache_ram.sv
`timescale 1ns/1ns
`default_nettype none

module cache_ram
    import cache_pkg::*;
#(
    parameter type entry_t = line_t,
    parameter int  DEPTH   = NSET
) (
    input  logic                     clk,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] waddr_i,
    input  entry_t                   wdata_i,
    input  logic                     re_i,
    input  logic [$clog2(DEPTH)-1:0] raddr_i,
    output entry_t                   rdata_o
);
    entry_t ram [DEPTH];

    always_ff @(posedge clk) begin
        if (we_i) begin
            ram[waddr_i] <= wdata_i;
        end
        // output keeps the last read while re_i is low
        if (re_i) begin
            rdata_o <= ram[raddr_i];
        end
    end

endmodule

`default_nettype wire

//--- src/dcache_lookup.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_lookup
    import cache_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid_i,
    input  logic                req_we_i,
    input  logic [ADDR_W-1:0]   req_addr_i,
    input  logic [WORD_W/8-1:0] req_wstrb_i,
    input  logic [WORD_W-1:0]   req_wdata_i,
    input  logic                hold_i,
    array_wr_if.arrays          arr,
    output lookup_t             lk_o
);
    logic                  accept;
    logic [INDEX_W-1:0]    rd_index;
    logic                  valid_q;
    logic                  we_q;
    logic [ADDR_W-1:0]     addr_q;
    logic [WORD_W/8-1:0]   wstrb_q;
    logic [WORD_W-1:0]     wdata_q;
    tag_entry_t [NWAY-1:0] tag_rd;
    line_t [NWAY-1:0]      line_rd;

    assign accept   = req_valid_i && !hold_i;
    assign rd_index = req_addr_i[OFFSET_W +: INDEX_W];

    // stage 2 empties when it advances without a new request
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (!hold_i) begin
            valid_q <= req_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            we_q    <= req_we_i;
            addr_q  <= req_addr_i;
            wstrb_q <= req_wstrb_i;
            wdata_q <= req_wdata_i;
        end
    end

    for (genvar w = 0; w < NWAY; w++) begin : g_way
        cache_ram #(
            .entry_t(tag_entry_t),
            .DEPTH  (NSET)
        ) u_tag_ram (
            .clk    (clk),
            .we_i   (arr.we && arr.way[w]),
            .waddr_i(arr.index),
            .wdata_i(arr.tag),
            .re_i   (accept),
            .raddr_i(rd_index),
            .rdata_o(tag_rd[w])
        );

        cache_ram #(
            .entry_t(line_t),
            .DEPTH  (NSET)
        ) u_line_ram (
            .clk    (clk),
            .we_i   (arr.we && arr.way[w]),
            .waddr_i(arr.index),
            .wdata_i(arr.line),
            .re_i   (accept),
            .raddr_i(rd_index),
            .rdata_o(line_rd[w])
        );
    end

    always_comb begin
        lk_o.valid = valid_q;
        lk_o.we    = we_q;
        lk_o.addr  = addr_q;
        lk_o.wstrb = wstrb_q;
        lk_o.wdata = wdata_q;
        lk_o.tags  = tag_rd;
        lk_o.lines = line_rd;
    end

endmodule

`default_nettype wire

//--- src/dcache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_ctrl
    import cache_pkg::*, bus_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid_i,
    input  lookup_t           lk_i,
    output logic              hold_o,
    output logic              ready_o,
    output logic              data_ok_o,
    output logic [WORD_W-1:0] rdata_o,
    array_wr_if.ctrl          arr,
    mem_line_if.ctrl          mem
);
    typedef enum logic [2:0] {INIT, IDLE, WRITEBACK, REFILL, RESPOND} state_t;

    state_t             state;
    logic [INDEX_W-1:0] init_idx;
    // per set, the way to evict next
    logic [NSET-1:0]    repl;
    logic               spent;
    logic [WORD_W-1:0]  resp_word;

    logic               active;
    logic               hit;
    logic               store_hit;
    logic               miss;
    logic               victim;
    logic               vic_dirty;
    logic [NWAY-1:0]    hit_way;
    logic [NWAY-1:0]    vic_way;
    logic [INDEX_W-1:0] idx;
    logic [TAG_W-1:0]   tag;
    logic [OFFSET_W-3:0] word;
    line_t              hit_line;
    line_t              merged;
    tag_entry_t         vic_entry;

    assign idx  = lk_i.addr[OFFSET_W +: INDEX_W];
    assign tag  = lk_i.addr[OFFSET_W + INDEX_W +: TAG_W];
    assign word = lk_i.addr[OFFSET_W-1:2];

    // a store already answered but still frozen in stage 2 is not a request
    assign active = lk_i.valid && !spent;

    always_comb begin
        hit_line = lk_i.lines[0];
        for (int w = 0; w < NWAY; w++) begin
            hit_way[w] = lk_i.tags[w].valid && (lk_i.tags[w].tag == tag);
            if (hit_way[w]) begin
                hit_line = lk_i.lines[w];
            end
        end
    end

    assign hit       = |hit_way;
    assign store_hit = (state == IDLE) && active && hit && lk_i.we;
    assign miss      = (state == IDLE) && active && !hit;

    assign victim    = repl[idx];
    assign vic_entry = lk_i.tags[victim];
    assign vic_dirty = vic_entry.valid && vic_entry.dirty;
    assign vic_way   = NWAY'(1) << victim;

    // store bytes go into the hit line, or into the refilled line on a miss
    always_comb begin
        merged = (state == REFILL) ? mem.rline : hit_line;
        if (lk_i.we) begin
            for (int b = 0; b < WORD_W / 8; b++) begin
                if (lk_i.wstrb[b]) begin
                    merged[word][8*b +: 8] = lk_i.wdata[8*b +: 8];
                end
            end
        end
    end

    assign ready_o   = (state == RESPOND) || ((state == IDLE) && !store_hit && !miss);
    // with nothing waiting, a finished store lets stage 2 drain
    assign hold_o    = !ready_o && !(store_hit && !req_valid_i);
    assign data_ok_o = (state == RESPOND) || ((state == IDLE) && active && hit);
    assign rdata_o   = (state == RESPOND) ? resp_word : hit_line[word];

    always_comb begin
        mem.start = 1'b0;
        mem.we    = 1'b0;
        mem.addr  = WB_AW'({tag, idx, {OFFSET_W{1'b0}}});
        mem.wline = lk_i.lines[victim];
        if (miss) begin
            mem.start = 1'b1;
            if (vic_dirty) begin
                mem.we   = 1'b1;
                mem.addr = WB_AW'({vic_entry.tag, idx, {OFFSET_W{1'b0}}});
            end
        end else if ((state == WRITEBACK) && mem.done) begin
            mem.start = 1'b1;
        end
    end

    always_comb begin
        arr.we    = 1'b0;
        arr.way   = hit_way;
        arr.index = idx;
        arr.tag   = '{valid: 1'b1, dirty: 1'b1, tag: tag};
        arr.line  = merged;
        case (state)
            INIT: begin
                // clear both ways of one set per cycle
                arr.we    = 1'b1;
                arr.way   = '1;
                arr.index = init_idx;
                arr.tag   = '0;
            end
            IDLE: begin
                arr.we = store_hit;
            end
            REFILL: begin
                arr.we        = mem.done;
                arr.way       = vic_way;
                arr.tag.dirty = lk_i.we;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= INIT;
            init_idx <= '0;
            repl     <= '0;
            spent    <= 1'b0;
        end else begin
            if (!hold_o) begin
                spent <= 1'b0;
            end else if (store_hit) begin
                spent <= 1'b1;
            end
            // point at the way that was not just used
            if ((state == IDLE) && active && hit) begin
                repl[idx] <= hit_way[0];
            end
            case (state)
                INIT: begin
                    init_idx <= init_idx + 1'b1;
                    if (init_idx == INDEX_W'(NSET - 1)) begin
                        state <= IDLE;
                    end
                end
                IDLE: begin
                    if (miss) begin
                        state <= vic_dirty ? WRITEBACK : REFILL;
                    end
                end
                WRITEBACK: begin
                    if (mem.done) begin
                        state <= REFILL;
                    end
                end
                REFILL: begin
                    if (mem.done) begin
                        state     <= RESPOND;
                        repl[idx] <= !victim;
                    end
                end
                RESPOND: begin
                    state <= IDLE;
                end
                default: begin
                    state <= INIT;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == REFILL) && mem.done) begin
            resp_word <= merged[word];
        end
    end

endmodule

`default_nettype wire

//--- src/wb_line_master.sv
`timescale 1ns/1ns
`default_nettype none

module wb_line_master
    import cache_pkg::*, bus_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    mem_line_if.master       mem,
    output logic             wb_cyc_o,
    output logic             wb_stb_o,
    output logic             wb_we_o,
    output logic [WB_AW-1:0] wb_adr_o,
    output logic [WB_SW-1:0] wb_sel_o,
    output logic [WB_DW-1:0] wb_dat_o,
    input  logic [WB_DW-1:0] wb_dat_i,
    input  logic             wb_ack_i
);
    logic                          busy;
    logic                          cyc_q;
    logic                          done_q;
    logic [$clog2(LINE_WORDS)-1:0] beat;
    logic                          we_q;
    logic [WB_AW-1:0]              base_q;
    line_t                         wline_q;
    line_t                         rline_q;

    // one single-word cycle per beat, cyc low for a cycle in between
    always_ff @(posedge clk) begin
        if (rst) begin
            busy   <= 1'b0;
            cyc_q  <= 1'b0;
            done_q <= 1'b0;
            beat   <= '0;
        end else begin
            done_q <= 1'b0;
            if (!busy) begin
                if (mem.start) begin
                    busy  <= 1'b1;
                    cyc_q <= 1'b1;
                    beat  <= '0;
                end
            end else if (cyc_q) begin
                if (wb_ack_i) begin
                    cyc_q <= 1'b0;
                    if (int'(beat) == LINE_WORDS - 1) begin
                        busy   <= 1'b0;
                        done_q <= 1'b1;
                    end else begin
                        beat <= beat + 1'b1;
                    end
                end
            end else begin
                cyc_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && mem.start) begin
            we_q    <= mem.we;
            base_q  <= mem.addr;
            wline_q <= mem.wline;
        end
        if (cyc_q && wb_ack_i && !we_q) begin
            rline_q[beat] <= wb_dat_i;
        end
    end

    assign wb_cyc_o = cyc_q;
    assign wb_stb_o = cyc_q;
    assign wb_we_o  = we_q;
    assign wb_adr_o = base_q + (WB_AW'(beat) << $clog2(WB_SW));
    assign wb_sel_o = '1;
    assign wb_dat_o = wline_q[beat];

    assign mem.done  = done_q;
    assign mem.rline = rline_q;

endmodule

`default_nettype wire

//--- src/dcache_top.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_top
    import cache_pkg::*, bus_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    // cpu load/store port
    input  logic                req_valid_i,
    input  logic                req_we_i,
    input  logic [ADDR_W-1:0]   req_addr_i,
    input  logic [WORD_W/8-1:0] req_wstrb_i,
    input  logic [WORD_W-1:0]   req_wdata_i,
    output logic                ready_o,
    output logic                data_ok_o,
    output logic [WORD_W-1:0]   rdata_o,
    // wishbone classic master
    output logic                wb_cyc_o,
    output logic                wb_stb_o,
    output logic                wb_we_o,
    output logic [WB_AW-1:0]    wb_adr_o,
    output logic [WB_SW-1:0]    wb_sel_o,
    output logic [WB_DW-1:0]    wb_dat_o,
    input  logic [WB_DW-1:0]    wb_dat_i,
    input  logic                wb_ack_i
);
    array_wr_if arr_if ();
    mem_line_if mem_if ();

    lookup_t lk;
    logic    hold;

    dcache_lookup u_lookup (
        .clk        (clk),
        .rst        (rst),
        .req_valid_i(req_valid_i),
        .req_we_i   (req_we_i),
        .req_addr_i (req_addr_i),
        .req_wstrb_i(req_wstrb_i),
        .req_wdata_i(req_wdata_i),
        .hold_i     (hold),
        .arr        (arr_if),
        .lk_o       (lk)
    );

    dcache_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .req_valid_i(req_valid_i),
        .lk_i       (lk),
        .hold_o     (hold),
        .ready_o    (ready_o),
        .data_ok_o  (data_ok_o),
        .rdata_o    (rdata_o),
        .arr        (arr_if),
        .mem        (mem_if)
    );

    wb_line_master u_wb_master (
        .clk     (clk),
        .rst     (rst),
        .mem     (mem_if),
        .wb_cyc_o(wb_cyc_o),
        .wb_stb_o(wb_stb_o),
        .wb_we_o (wb_we_o),
        .wb_adr_o(wb_adr_o),
        .wb_sel_o(wb_sel_o),
        .wb_dat_o(wb_dat_o),
        .wb_dat_i(wb_dat_i),
        .wb_ack_i(wb_ack_i)
    );

endmodule

`default_nettype wire

//--- bench/dcache_props.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_props
    import bus_pkg::*;
(
    input wire logic                          clk,
    input wire logic                          rst,
    input wire logic                          cyc_i,
    input wire logic                          stb_i,
    input wire logic                          we_i,
    input wire logic [WB_AW-1:0]              adr_i,
    input wire logic [WB_DW-1:0]              dat_i,
    input wire logic                          ack_i,
    input wire logic [$clog2(LINE_WORDS)-1:0] beat_i,
    input wire logic                          done_i
);
    // every beat is its own cycle, so cyc drops after each ack
    a_cyc_drops_after_ack: assert property (@(posedge clk) disable iff (rst)
        cyc_i && ack_i |=> !cyc_i)
        else $error("wishbone cyc stayed high after ack");

    // a beat keeps its address, data and direction until the slave acks
    a_stable_until_ack: assert property (@(posedge clk) disable iff (rst)
        stb_i && !ack_i |=> stb_i && $stable(adr_i) && $stable(dat_i) && $stable(we_i))
        else $error("wishbone beat changed before ack");

    a_done_after_last: assert property (@(posedge clk) disable iff (rst)
        cyc_i && ack_i && (int'(beat_i) == LINE_WORDS - 1) |=> done_i)
        else $error("line done missing after the fourth ack");

    a_done_only_after_last: assert property (@(posedge clk) disable iff (rst)
        done_i |-> $past(cyc_i && ack_i && (int'(beat_i) == LINE_WORDS - 1)))
        else $error("line done without a fourth ack before it");
endmodule

bind wb_line_master dcache_props u_props (
    .clk   (clk),
    .rst   (rst),
    .cyc_i (wb_cyc_o),
    .stb_i (wb_stb_o),
    .we_i  (wb_we_o),
    .adr_i (wb_adr_o),
    .dat_i (wb_dat_o),
    .ack_i (wb_ack_i),
    .beat_i(beat),
    .done_i(done_q)
);

`default_nettype wire

//--- bench/dcache_checker.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_checker
    import cache_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        req_valid_i,
    input  wire logic        ready_i,
    input  wire logic        data_ok_i,
    input  wire logic [31:0] rdata_i,
    input  wire logic        wb_cyc_i,
    input  wire logic        wb_stb_i,
    input  wire logic        wb_we_i,
    input  wire logic [3:0]  wb_sel_i,
    input  wire logic        wb_ack_i,
    input  wire logic [7:0]  entry_i,
    input  wire logic        exp_load_i,
    input  wire logic [31:0] exp_rdata_i,
    input  wire logic        exp_hit_i,
    input  wire logic        exp_wb_i,
    input  wire logic        end_i,
    output logic             idle_o,
    output logic             finished_o,
    output int               errors_o
);
    int          cycle;
    int          accepted;
    int          oks;
    int          wr_beats;
    int          exp_wr_beats;
    int          errors;
    int          reset_low;
    bit          reset_seen;
    bit          finished;
    int          q_entry [$];
    int          q_cycle [$];
    bit          q_load [$];
    bit          q_hit [$];
    logic [31:0] q_rdata [$];

    initial begin
        accepted     = 0;
        oks          = 0;
        wr_beats     = 0;
        exp_wr_beats = 0;
        errors       = 0;
        finished     = 1'b0;
    end

    always @(posedge clk) begin
        int          ent;
        int          acc_cycle;
        bit          ld;
        bit          hit;
        logic [31:0] exp;
        if (rst) begin
            cycle      = 0;
            reset_low  = 0;
            reset_seen = 1'b0;
        end else begin
            cycle++;
            // the set walk after reset keeps ready low for one cycle per set
            if (!reset_seen) begin
                if (!ready_i) begin
                    reset_low++;
                end else begin
                    reset_seen = 1'b1;
                    if (reset_low != NSET) begin
                        $display("ready_o stayed low for %0d cycles after reset, expected %0d",
                                 reset_low, NSET);
                        errors++;
                    end
                end
            end
            if (data_ok_i) begin
                if (q_entry.size() == 0) begin
                    $display("data_ok_o pulsed with no request outstanding");
                    errors++;
                end else begin
                    ent       = q_entry.pop_front();
                    acc_cycle = q_cycle.pop_front();
                    ld        = q_load.pop_front();
                    hit       = q_hit.pop_front();
                    exp       = q_rdata.pop_front();
                    oks++;
                    if (ld && (rdata_i !== exp)) begin
                        $display("** Error rdata_o entry %0d: got %h expected %h",
                                 ent, rdata_i, exp);
                        errors++;
                    end
                    if (hit && (cycle - acc_cycle != 1)) begin
                        $display("entry %0d was a hit but answered %0d cycles after acceptance",
                                 ent, cycle - acc_cycle);
                        errors++;
                    end
                end
            end
            if (req_valid_i && ready_i) begin
                q_entry.push_back(int'(entry_i));
                q_cycle.push_back(cycle);
                q_load.push_back(exp_load_i);
                q_hit.push_back(exp_hit_i);
                q_rdata.push_back(exp_rdata_i);
                accepted++;
                if (exp_wb_i) begin
                    exp_wr_beats += 4;
                end
            end
            if (wb_cyc_i && wb_ack_i && wb_we_i) begin
                wr_beats++;
            end
            // stb follows cyc, and every beat moves the whole word
            if (wb_stb_i !== wb_cyc_i) begin
                $display("** Error wb_stb_o: got %h expected %h", wb_stb_i, wb_cyc_i);
                errors++;
            end
            if (wb_cyc_i && (wb_sel_i !== 4'hf)) begin
                $display("** Error wb_sel_o: got %h expected %h", wb_sel_i, 4'hf);
                errors++;
            end
            if (end_i && !finished) begin
                if (wr_beats != exp_wr_beats) begin
                    $display("** Error wb write beats: got %h expected %h",
                             wr_beats, exp_wr_beats);
                    errors++;
                end
                if (accepted != oks) begin
                    $display("%0d requests accepted but %0d data_ok_o pulses seen",
                             accepted, oks);
                    errors++;
                end
                $display("errors %0d, requests %0d, responses %0d, write beats %0d",
                         errors, accepted, oks, wr_beats);
                finished = 1'b1;
            end
        end
    end

    assign idle_o     = (accepted == oks);
    assign finished_o = finished;
    assign errors_o   = errors;

endmodule

`default_nettype wire

//--- bench/tb_dcache.sv
`timescale 1ns/1ns
`default_nettype none

module tb_dcache;
    typedef struct packed {
        logic        we;
        logic [31:0] addr;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic        hit;
        logic        wb;
    } stim_t;

    localparam int N     = 18;
    localparam int LIMIT = 200 * N + 100 + 16;

    // set 0 loads, set 1 byte merges, set 2 evictions (0x020, 0x120, 0x220)
    localparam stim_t STIM [N] = '{
        '{1'b0, 32'h004, 4'h0, 32'h0,        32'h5a5a0004, 1'b0, 1'b0},
        '{1'b0, 32'h004, 4'h0, 32'h0,        32'h5a5a0004, 1'b1, 1'b0},
        '{1'b0, 32'h008, 4'h0, 32'h0,        32'h5a5a0008, 1'b1, 1'b0},
        '{1'b1, 32'h014, 4'h1, 32'h000000a5, 32'h0,        1'b0, 1'b0},
        '{1'b0, 32'h014, 4'h0, 32'h0,        32'h5a5a00a5, 1'b1, 1'b0},
        '{1'b1, 32'h014, 4'hc, 32'hbeef0000, 32'h0,        1'b1, 1'b0},
        '{1'b0, 32'h014, 4'h0, 32'h0,        32'hbeef00a5, 1'b1, 1'b0},
        '{1'b1, 32'h018, 4'hf, 32'h12345678, 32'h0,        1'b1, 1'b0},
        '{1'b0, 32'h018, 4'h0, 32'h0,        32'h12345678, 1'b1, 1'b0},
        '{1'b0, 32'h01c, 4'h0, 32'h0,        32'h5a5a001c, 1'b1, 1'b0},
        '{1'b1, 32'h020, 4'hf, 32'h11111111, 32'h0,        1'b0, 1'b0},
        '{1'b1, 32'h120, 4'hf, 32'h22222222, 32'h0,        1'b0, 1'b0},
        '{1'b1, 32'h220, 4'hf, 32'h33333333, 32'h0,        1'b0, 1'b1},
        '{1'b0, 32'h020, 4'h0, 32'h0,        32'h11111111, 1'b0, 1'b1},
        '{1'b0, 32'h124, 4'h0, 32'h0,        32'h5a5a0124, 1'b0, 1'b1},
        '{1'b0, 32'h120, 4'h0, 32'h0,        32'h22222222, 1'b1, 1'b0},
        '{1'b0, 32'h224, 4'h0, 32'h0,        32'h5a5a0224, 1'b0, 1'b0},
        '{1'b0, 32'h220, 4'h0, 32'h0,        32'h33333333, 1'b1, 1'b0}
    };

    logic        clk;
    logic        rst;
    logic        req_valid;
    logic        req_we;
    logic [31:0] req_addr;
    logic [3:0]  req_wstrb;
    logic [31:0] req_wdata;
    logic        ready;
    logic        data_ok;
    logic [31:0] rdata;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [3:0]  wb_sel;
    logic [31:0] wb_dat_o;
    logic [31:0] wb_dat_i;
    logic        wb_ack;
    logic [7:0]  entry;
    logic        exp_load;
    logic [31:0] exp_rdata;
    logic        exp_hit;
    logic        exp_wb;
    logic        end_req;
    logic        idle;
    logic        finished;
    int          errors;
    int          cycles;
    logic [31:0] mem [4096];
    logic [31:0] rnd;
    logic [1:0]  wait_left;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    dcache_top DUT (
        .clk(clk), .rst(rst),
        .req_valid_i(req_valid), .req_we_i(req_we), .req_addr_i(req_addr),
        .req_wstrb_i(req_wstrb), .req_wdata_i(req_wdata),
        .ready_o(ready), .data_ok_o(data_ok), .rdata_o(rdata),
        .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_adr_o(wb_adr),
        .wb_sel_o(wb_sel), .wb_dat_o(wb_dat_o), .wb_dat_i(wb_dat_i), .wb_ack_i(wb_ack)
    );

    dcache_checker u_checker (
        .clk(clk), .rst(rst),
        .req_valid_i(req_valid), .ready_i(ready), .data_ok_i(data_ok), .rdata_i(rdata),
        .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_sel_i(wb_sel),
        .wb_ack_i(wb_ack),
        .entry_i(entry), .exp_load_i(exp_load), .exp_rdata_i(exp_rdata),
        .exp_hit_i(exp_hit), .exp_wb_i(exp_wb), .end_i(end_req),
        .idle_o(idle), .finished_o(finished), .errors_o(errors)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // every word starts as its own byte address xor a fixed pattern
    initial begin
        for (int i = 0; i < 4096; i++) begin
            mem[i] = (32'(i) << 2) ^ 32'h5a5a0000;
        end
    end

    // wishbone slave with 0 to 3 wait states per beat
    always @(posedge clk) begin
        if (rst) begin
            wb_ack    <= 1'b0;
            wait_left <= 2'd0;
        end else if (wb_ack) begin
            wb_ack <= 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (wait_left == 2'd0) begin
                wb_ack <= 1'b1;
                if (wb_we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (wb_sel[b]) begin
                            mem[wb_adr[13:2]][8*b +: 8] <= wb_dat_o[8*b +: 8];
                        end
                    end
                end else begin
                    wb_dat_i <= mem[wb_adr[13:2]];
                end
                rnd = lcg_next(rnd);
                wait_left <= rnd[31:30];
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles without finishing the table", LIMIT);
        $display("Test failed");
        $finish;
    end

    initial begin
        rnd       = 32'h03eba75d;
        rst       = 1'b1;
        req_valid = 1'b0;
        req_we    = 1'b0;
        req_addr  = '0;
        req_wstrb = '0;
        req_wdata = '0;
        wb_dat_i  = '0;
        wb_ack    = 1'b0;
        entry     = '0;
        exp_load  = 1'b0;
        exp_rdata = '0;
        exp_hit   = 1'b0;
        exp_wb    = 1'b0;
        end_req   = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        // next entry goes out on the edge that accepts the current one
        for (int i = 0; i < N; i++) begin
            req_valid <= 1'b1;
            req_we    <= STIM[i].we;
            req_addr  <= STIM[i].addr;
            req_wstrb <= STIM[i].wstrb;
            req_wdata <= STIM[i].wdata;
            entry     <= 8'(i);
            exp_load  <= !STIM[i].we;
            exp_rdata <= STIM[i].rdata;
            exp_hit   <= STIM[i].hit;
            exp_wb    <= STIM[i].wb;
            do begin
                @(posedge clk);
            end while (!ready);
        end
        req_valid <= 1'b0;
        @(negedge clk);
        while (!idle) begin
            @(negedge clk);
        end
        @(posedge clk);
        end_req <= 1'b1;
        @(negedge clk);
        while (!finished) begin
            @(negedge clk);
        end
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
src/cache_pkg.sv
src/bus_pkg.sv
src/dcache_ifs.sv
src/cache_ram.sv
src/dcache_lookup.sv
src/dcache_ctrl.sv
src/wb_line_master.sv
src/dcache_top.sv
bench/dcache_props.sv
bench/dcache_checker.sv
bench/tb_dcache.sv

//--- run.sh
#!/bin/sh
# build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f flist.f \
    --top-module tb_dcache \
    --Mdir obj_dir \
    -o tb_dcache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_dcache_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
